// ==== car_cfg_pkg.sv ====
package car_cfg_pkg;

    // sensor front end
    localparam int sync_stages = 2;
    localparam int filter_cycles = 3;
    localparam int filt_width = $clog2(filter_cycles + 1);
    localparam logic [filt_width-1:0] filt_last = filt_width'(filter_cycles - 1);
    // counter parks here once a pattern has settled
    localparam logic [filt_width-1:0] filt_done = filt_width'(filter_cycles);

    // sample buffer
    localparam int fifo_depth = 4;
    localparam int ptr_width = $clog2(fifo_depth);
    localparam int occ_width = $clog2(fifo_depth + 1);
    localparam logic [ptr_width-1:0] ptr_last = ptr_width'(fifo_depth - 1);
    localparam logic [occ_width-1:0] occ_full = occ_width'(fifo_depth);

    // steering, board value is far larger
    localparam int cnt_width = 8;
    localparam logic [cnt_width-1:0] cross_hold_cycles = cnt_width'(40);

    // motor pwm
    localparam int pwm_period = 16;
    localparam int pwm_width = $clog2(pwm_period);
    localparam int duty_width = pwm_width + 1;
    localparam logic [pwm_width-1:0] pwm_last = pwm_width'(pwm_period - 1);
    localparam logic [duty_width-1:0] duty_full = duty_width'(12);
    localparam logic [duty_width-1:0] duty_slow = duty_width'(4);

    // display scan
    localparam int scan_div = 8;
    localparam int scan_width = $clog2(scan_div);
    localparam logic [scan_width-1:0] scan_last = scan_width'(scan_div - 1);

endpackage

// ==== car_types_pkg.sv ====
package car_types_pkg;

    // drive action, codes double as the display digit
    typedef enum logic [1:0] {
        stop        = 2'b00,
        turn_right  = 2'b01,
        turn_left   = 2'b10,
        go_straight = 2'b11
    } drive_state_t;

    // one bit per reflective sensor, 1 means over the line
    typedef struct packed {
        logic left;
        logic mid;
        logic right;
    } track_pattern_t;

    // accepted pattern as it travels through the buffer
    typedef struct packed {
        track_pattern_t pattern;
        // an unaccepted change happened since the previous sample
        logic           glitch;
    } sensor_sample_t;

    // pwm level per wheel
    typedef struct packed {
        logic left_pwm;
        logic right_pwm;
    } motor_cmd_t;

endpackage

// ==== track_sampler.sv ====
`timescale 1ns/1ps

module track_sampler (
    input  logic                          clk,
    input  logic                          reset,
    input  car_types_pkg::track_pattern_t tracks,
    output logic                          sample_push,
    output car_types_pkg::sensor_sample_t sample_data
);

    // synchronizer chain, the top index is the oldest stage
    car_types_pkg::track_pattern_t [car_cfg_pkg::sync_stages-1:0] sync_q;
    car_types_pkg::track_pattern_t synced;
    car_types_pkg::track_pattern_t cand_q;
    car_types_pkg::track_pattern_t last_q;
    logic [car_cfg_pkg::filt_width-1:0] stable_cnt;
    logic glitch_q;
    logic accept;

    assign synced = sync_q[car_cfg_pkg::sync_stages-1];

    // third equal clock of a new pattern
    assign accept = (synced == cand_q) && (stable_cnt == car_cfg_pkg::filt_last) &&
                    (synced != last_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q      <= '0;
            cand_q      <= '0;
            last_q      <= '0;
            stable_cnt  <= car_cfg_pkg::filt_done;
            glitch_q    <= 1'b0;
            sample_push <= 1'b0;
        end else begin
            sync_q      <= {sync_q[car_cfg_pkg::sync_stages-2:0], tracks};
            sample_push <= accept;
            if (synced != cand_q) begin
                cand_q     <= synced;
                stable_cnt <= '0;
                // previous candidate never settled
                if (stable_cnt != car_cfg_pkg::filt_done) begin
                    glitch_q <= 1'b1;
                end
            end else if (stable_cnt != car_cfg_pkg::filt_done) begin
                stable_cnt <= stable_cnt + 1'b1;
            end
            if (accept) begin
                last_q   <= synced;
                glitch_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sample_data <= '{pattern: synced, glitch: glitch_q};
        end
    end

    // counter saturates after a push, so the strobe cannot repeat
    assert property (@(posedge clk) disable iff (reset) sample_push |=> !sample_push)
        else $error("track_sampler: push strobe high for two cycles");

endmodule

// ==== sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          push,
    input  car_types_pkg::sensor_sample_t push_data,
    input  logic                          pop,
    output logic                          not_empty,
    output car_types_pkg::sensor_sample_t head
);

    car_types_pkg::sensor_sample_t mem [car_cfg_pkg::fifo_depth];
    logic [car_cfg_pkg::ptr_width-1:0] wr_ptr;
    logic [car_cfg_pkg::ptr_width-1:0] rd_ptr;
    logic [car_cfg_pkg::occ_width-1:0] count;
    logic full;
    logic do_push;
    logic do_pop;

    function automatic logic [car_cfg_pkg::ptr_width-1:0] ptr_step(
        input logic [car_cfg_pkg::ptr_width-1:0] ptr
    );
        if (ptr == car_cfg_pkg::ptr_last) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == car_cfg_pkg::occ_full);
    assign not_empty = (count != '0);
    // first word fall through
    assign head      = mem[rd_ptr];

    // full buffer drops the incoming sample
    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // consumer only pops on the flag it was shown
    assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
        else $error("sample_fifo: pop while empty");

    // steering pops every cycle, so filling up means the consumer stalled
    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("sample_fifo: push while full, sample dropped");

endmodule

// ==== steering_fsm.sv ====
`timescale 1ns/1ps

module steering_fsm (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          not_empty,
    input  car_types_pkg::sensor_sample_t head,
    output logic                          pop,
    output car_types_pkg::track_pattern_t pattern,
    output car_types_pkg::drive_state_t   drive_state
);

    car_types_pkg::drive_state_t next_state;
    // set when the start position shows 011
    logic orient_flag;
    logic all_on;
    logic hold_over;
    logic [car_cfg_pkg::cnt_width-1:0] on_cnt;

    // consumer never stalls
    assign pop = not_empty;

    assign all_on    = (pattern == 3'b111);
    assign hold_over = (on_cnt > car_cfg_pkg::cross_hold_cycles);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pattern     <= '0;
            on_cnt      <= '0;
            orient_flag <= 1'b0;
            drive_state <= car_types_pkg::stop;
        end else begin
            if (pop) begin
                pattern <= head.pattern;
            end
            // all-on run length, held at the top
            if (!all_on) begin
                on_cnt <= '0;
            end else if (on_cnt != '1) begin
                on_cnt <= on_cnt + 1'b1;
            end
            if (drive_state == car_types_pkg::stop && pattern == 3'b011) begin
                orient_flag <= 1'b1;
            end
            drive_state <= next_state;
        end
    end

    always_comb begin
        next_state = drive_state;
        case (drive_state)
            car_types_pkg::stop: begin
                if (pattern == 3'b110 || pattern == 3'b011) begin
                    next_state = car_types_pkg::go_straight;
                end
            end
            car_types_pkg::go_straight: begin
                if (!all_on) begin
                    next_state = orient_flag ? car_types_pkg::turn_right
                                             : car_types_pkg::turn_left;
                end else if (hold_over) begin
                    // long crossing or wide mark
                    next_state = orient_flag ? car_types_pkg::turn_left
                                             : car_types_pkg::turn_right;
                end
            end
            car_types_pkg::turn_left: begin
                // flag clear needs all-on, flag set needs anything else
                if (orient_flag != all_on) begin
                    next_state = car_types_pkg::go_straight;
                end
            end
            car_types_pkg::turn_right: begin
                if (orient_flag == all_on) begin
                    next_state = car_types_pkg::go_straight;
                end
            end
            default: next_state = drive_state;
        endcase
    end

    // car always passes through go_straight when leaving stop
    assert property (@(posedge clk) disable iff (reset)
        (drive_state == car_types_pkg::stop) |=>
        (drive_state inside {car_types_pkg::stop, car_types_pkg::go_straight}))
        else $error("steering_fsm: stop went straight to a turn");

endmodule

// ==== motor_pwm.sv ====
`timescale 1ns/1ps

module motor_pwm (
    input  logic                        clk,
    input  logic                        reset,
    input  car_types_pkg::drive_state_t drive_state,
    output car_types_pkg::motor_cmd_t   motor
);

    logic [car_cfg_pkg::pwm_width-1:0]  pwm_cnt;
    logic [car_cfg_pkg::duty_width-1:0] duty_left;
    logic [car_cfg_pkg::duty_width-1:0] duty_right;
    logic [car_cfg_pkg::duty_width-1:0] next_left;
    logic [car_cfg_pkg::duty_width-1:0] next_right;

    // inner wheel slows down in a turn
    always_comb begin
        case (drive_state)
            car_types_pkg::go_straight: begin
                next_left  = car_cfg_pkg::duty_full;
                next_right = car_cfg_pkg::duty_full;
            end
            car_types_pkg::turn_left: begin
                next_left  = car_cfg_pkg::duty_slow;
                next_right = car_cfg_pkg::duty_full;
            end
            car_types_pkg::turn_right: begin
                next_left  = car_cfg_pkg::duty_full;
                next_right = car_cfg_pkg::duty_slow;
            end
            default: begin
                next_left  = '0;
                next_right = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm_cnt    <= '0;
            duty_left  <= '0;
            duty_right <= '0;
        end else if (pwm_cnt == car_cfg_pkg::pwm_last) begin
            // new duties apply from the next period start
            pwm_cnt    <= '0;
            duty_left  <= next_left;
            duty_right <= next_right;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
        end
    end

    assign motor = '{left_pwm:  ({1'b0, pwm_cnt} < duty_left),
                     right_pwm: ({1'b0, pwm_cnt} < duty_right)};

endmodule

// ==== seg_display.sv ====
`timescale 1ns/1ps

module seg_display (
    input  logic                          clk,
    input  logic                          reset,
    input  car_types_pkg::drive_state_t   drive_state,
    input  car_types_pkg::track_pattern_t pattern,
    output logic [6:0]                    seg,
    output logic [3:0]                    digit
);

    logic [car_cfg_pkg::scan_width-1:0] scan_cnt;
    logic scan_en;
    logic scan_started;
    logic [1:0] value;

    assign scan_en = (scan_cnt == car_cfg_pkg::scan_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scan_cnt     <= '0;
            digit        <= 4'b1111;
            scan_started <= 1'b0;
        end else begin
            scan_cnt <= scan_en ? '0 : scan_cnt + 1'b1;
            if (scan_en) begin
                scan_started <= 1'b1;
                // rightmost digit first, wrap after the action digit
                case (digit)
                    4'b1110: digit <= 4'b1101;
                    4'b1101: digit <= 4'b1011;
                    4'b1011: digit <= 4'b0111;
                    default: digit <= 4'b1110;
                endcase
            end
        end
    end

    // value shown on the active digit
    always_comb begin
        case (digit)
            4'b1110: value = {1'b0, pattern.right};
            4'b1101: value = {1'b0, pattern.mid};
            4'b1011: value = {1'b0, pattern.left};
            default: value = drive_state;
        endcase
    end

    // active low segments, blank before the first step
    always_comb begin
        if (digit == 4'b1111) begin
            seg = 7'b1111111;
        end else begin
            case (value)
                2'd0:    seg = 7'b1000000;
                2'd1:    seg = 7'b1111001;
                2'd2:    seg = 7'b0100100;
                default: seg = 7'b0110000;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) scan_started |-> $onehot(~digit))
        else $error("seg_display: digit select not one-hot");

endmodule

// ==== line_tracker_top.sv ====
`timescale 1ns/1ps

module line_tracker_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        left_track,
    input  logic                        mid_track,
    input  logic                        right_track,
    output car_types_pkg::drive_state_t drive_state,
    output car_types_pkg::motor_cmd_t   motor,
    output logic [6:0]                  seg,
    output logic [3:0]                  digit
);

    car_types_pkg::track_pattern_t tracks;
    car_types_pkg::sensor_sample_t sample_data;
    car_types_pkg::sensor_sample_t head;
    car_types_pkg::track_pattern_t pattern;
    logic sample_push;
    logic not_empty;
    logic pop;

    assign tracks = '{left: left_track, mid: mid_track, right: right_track};

    // sensors to sample stream
    track_sampler u_sampler (
        .clk         (clk),
        .reset       (reset),
        .tracks      (tracks),
        .sample_push (sample_push),
        .sample_data (sample_data)
    );

    sample_fifo u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (sample_push),
        .push_data (sample_data),
        .pop       (pop),
        .not_empty (not_empty),
        .head      (head)
    );

    steering_fsm u_steering (
        .clk         (clk),
        .reset       (reset),
        .not_empty   (not_empty),
        .head        (head),
        .pop         (pop),
        .pattern     (pattern),
        .drive_state (drive_state)
    );

    // action to wheels and display
    motor_pwm u_pwm (
        .clk         (clk),
        .reset       (reset),
        .drive_state (drive_state),
        .motor       (motor)
    );

    seg_display u_display (
        .clk         (clk),
        .reset       (reset),
        .drive_state (drive_state),
        .pattern     (pattern),
        .seg         (seg),
        .digit       (digit)
    );

endmodule

// ==== tb_line_tracker.sv ====
`timescale 1ns/1ps

module tb_line_tracker;

    logic clk = 1'b0;
    logic reset;
    logic left_track;
    logic mid_track;
    logic right_track;
    car_types_pkg::drive_state_t drive_state;
    car_types_pkg::motor_cmd_t   motor;
    logic [6:0] seg;
    logic [3:0] digit;

    int errors = 0;
    int timeouts = 0;
    int seed = 45545;
    // clocks since the sensor inputs last changed
    int run_len = 0;
    logic [2:0] last_in = 3'b000;
    // reference steering state and orientation flag
    car_types_pkg::drive_state_t model_state;
    logic model_flag;

    line_tracker_top dut (
        .clk         (clk),
        .reset       (reset),
        .left_track  (left_track),
        .mid_track   (mid_track),
        .right_track (right_track),
        .drive_state (drive_state),
        .motor       (motor),
        .seg         (seg),
        .digit       (digit)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if ({left_track, mid_track, right_track} != last_in) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
        last_in <= {left_track, mid_track, right_track};
    end

    function automatic string state_name(input car_types_pkg::drive_state_t s);
        case (s)
            car_types_pkg::stop:        return "stop";
            car_types_pkg::go_straight: return "straight";
            car_types_pkg::turn_left:   return "left";
            default:                    return "right";
        endcase
    endfunction

    function automatic car_types_pkg::drive_state_t parse_state(input string s);
        if (s == "straight") begin
            return car_types_pkg::go_straight;
        end
        if (s == "left") begin
            return car_types_pkg::turn_left;
        end
        if (s == "right") begin
            return car_types_pkg::turn_right;
        end
        return car_types_pkg::stop;
    endfunction

    // active low segments for 0 to 3
    function automatic logic [6:0] seg_code(input logic [1:0] v);
        case (v)
            2'd0:    return 7'b1000000;
            2'd1:    return 7'b1111001;
            2'd2:    return 7'b0100100;
            default: return 7'b0110000;
        endcase
    endfunction

    // steering table applied until the state stops moving
    task automatic model_settle(input logic [2:0] p, input int run);
        logic all_on;
        logic over;
        all_on = (p == 3'b111);
        over = all_on && (run > int'(car_cfg_pkg::cross_hold_cycles));
        repeat (4) begin
            case (model_state)
                car_types_pkg::stop: begin
                    if (p == 3'b011) begin
                        model_flag = 1'b1;
                    end
                    if (p == 3'b011 || p == 3'b110) begin
                        model_state = car_types_pkg::go_straight;
                    end
                end
                car_types_pkg::go_straight: begin
                    if (!all_on) begin
                        model_state = model_flag ? car_types_pkg::turn_right
                                                 : car_types_pkg::turn_left;
                    end else if (over) begin
                        model_state = model_flag ? car_types_pkg::turn_left
                                                 : car_types_pkg::turn_right;
                    end
                end
                car_types_pkg::turn_left: begin
                    if ((!model_flag && all_on) || (model_flag && !all_on)) begin
                        model_state = car_types_pkg::go_straight;
                    end
                end
                default: begin
                    if ((model_flag && all_on) || (!model_flag && !all_on)) begin
                        model_state = car_types_pkg::go_straight;
                    end
                end
            endcase
        end
    endtask

    task automatic drive_pattern(input logic [2:0] p);
        @(posedge clk);
        left_track  <= p[2];
        mid_track   <= p[1];
        right_track <= p[0];
    endtask

    task automatic check_state(input string name, input car_types_pkg::drive_state_t exp);
        assert (drive_state == exp) else begin
            errors++;
            $display("Fail %s: drive_state expected %s actual %s", name,
                     state_name(exp), state_name(drive_state));
        end
    endtask

    task automatic wait_state(input string name, input car_types_pkg::drive_state_t exp);
        int n;
        n = 0;
        @(negedge clk);
        while (drive_state != exp && n < 60) begin
            @(negedge clk);
            n++;
        end
        if (drive_state != exp) begin
            timeouts++;
            $display("timeout in %s: drive_state never became %s", name, state_name(exp));
        end
    endtask

    task automatic wait_digit(input string name, input logic [3:0] sel);
        int n;
        n = 0;
        @(negedge clk);
        while (digit != sel && n < 4 * car_cfg_pkg::scan_div + 4) begin
            @(negedge clk);
            n++;
        end
        if (digit != sel) begin
            timeouts++;
            $display("timeout in %s: digit select %b never came up", name, sel);
        end
    endtask

    task automatic apply_reset(input string name);
        int high;
        @(posedge clk);
        reset       <= 1'b1;
        left_track  <= 1'b0;
        mid_track   <= 1'b0;
        right_track <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        model_state = car_types_pkg::stop;
        model_flag = 1'b0;
        @(negedge clk);
        check_state(name, car_types_pkg::stop);
        assert (digit == 4'b1111) else begin
            errors++;
            $display("Fail %s: digit expected 1111 actual %b", name, digit);
        end
        high = 0;
        repeat (car_cfg_pkg::pwm_period) begin
            if (motor.left_pwm || motor.right_pwm) begin
                high++;
            end
            @(negedge clk);
        end
        assert (high == 0) else begin
            errors++;
            $display("Fail %s: motor high clocks expected 0 actual %0d", name, high);
        end
    endtask

    task automatic hold_pattern(input string name, input logic [2:0] p, input int hold,
                                input car_types_pkg::drive_state_t exp);
        int len;
        len = hold + int'($unsigned($random(seed)) % 4);
        drive_pattern(p);
        repeat (len) @(posedge clk);
        wait_state(name, exp);
        check_state(name, exp);
        model_settle(p, run_len);
        assert (model_state == exp) else begin
            errors++;
            $display("steering model gives %s but test %s expects %s",
                     state_name(model_state), name, state_name(exp));
        end
    endtask

    // pulses shorter than the filter must leave the action alone
    task automatic glitch_pulses(input string name, input logic [2:0] base, input int count,
                                 input car_types_pkg::drive_state_t exp);
        int width;
        logic [2:0] mask;
        drive_pattern(base);
        repeat (count) begin
            width = 1 + int'($unsigned($random(seed)) % 2);
            mask = 3'(1 + $unsigned($random(seed)) % 7);
            drive_pattern(base ^ mask);
            repeat (width - 1) @(posedge clk);
            drive_pattern(base);
            // watch for longer than the sensor to action latency
            repeat (12) begin
                @(negedge clk);
                check_state(name, exp);
            end
        end
    endtask

    task automatic check_pwm(input string name, input car_types_pkg::drive_state_t exp);
        int n;
        int left_hi;
        int right_hi;
        int exp_l;
        int exp_r;
        logic prev;
        exp_l = (exp == car_types_pkg::stop) ? 0 :
                (exp == car_types_pkg::turn_left) ? 4 : 12;
        exp_r = (exp == car_types_pkg::stop) ? 0 :
                (exp == car_types_pkg::turn_right) ? 4 : 12;
        @(negedge clk);
        check_state(name, exp);
        n = 0;
        if (exp != car_types_pkg::stop) begin
            // left wheel rises at every period start while driving
            prev = motor.left_pwm;
            @(negedge clk);
            while (!(motor.left_pwm && !prev) && n < 2 * car_cfg_pkg::pwm_period) begin
                prev = motor.left_pwm;
                @(negedge clk);
                n++;
            end
            if (n >= 2 * car_cfg_pkg::pwm_period) begin
                timeouts++;
                $display("timeout in %s: no pwm period start seen", name);
            end
        end
        left_hi = 0;
        right_hi = 0;
        repeat (car_cfg_pkg::pwm_period) begin
            if (motor.left_pwm) begin
                left_hi++;
            end
            if (motor.right_pwm) begin
                right_hi++;
            end
            @(negedge clk);
        end
        assert (left_hi == exp_l) else begin
            errors++;
            $display("Fail %s: left high clocks expected %0d actual %0d", name, exp_l, left_hi);
        end
        assert (right_hi == exp_r) else begin
            errors++;
            $display("Fail %s: right high clocks expected %0d actual %0d", name, exp_r, right_hi);
        end
    endtask

    task automatic check_display(input string name, input car_types_pkg::drive_state_t exp,
                                 input logic [2:0] p);
        @(negedge clk);
        check_state(name, exp);
        wait_digit(name, 4'b0111);
        assert (seg == seg_code(exp)) else begin
            errors++;
            $display("Fail %s: action segments expected %b actual %b", name, seg_code(exp), seg);
        end
        wait_digit(name, 4'b1110);
        assert (seg == seg_code({1'b0, p[0]})) else begin
            errors++;
            $display("Fail %s: right sensor segments expected %b actual %b", name,
                     seg_code({1'b0, p[0]}), seg);
        end
    endtask

    initial begin
        int fd;
        int n;
        int hold;
        int records;
        logic done;
        logic [2:0] pat;
        string name;
        string op;
        string exp_name;
        string rest;
        car_types_pkg::drive_state_t exp;
        reset       <= 1'b1;
        left_track  <= 1'b0;
        mid_track   <= 1'b0;
        right_track <= 1'b0;
        model_state = car_types_pkg::stop;
        model_flag = 1'b0;
        records = 0;
        done = 1'b0;
        fd = $fopen("line_tracker_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open line_tracker_tests.txt");
            done = 1'b1;
        end
        while (!done) begin
            n = $fscanf(fd, "%s", name);
            if (n != 1) begin
                done = 1'b1;
            end else if (name == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%s %b %d %s", op, pat, hold, exp_name);
                exp = parse_state(exp_name);
                records++;
                if (n != 4) begin
                    errors++;
                    $display("test record %s is incomplete", name);
                    done = 1'b1;
                end else if (op == "reset") begin
                    apply_reset(name);
                end else if (op == "hold") begin
                    hold_pattern(name, pat, hold, exp);
                end else if (op == "glitch") begin
                    glitch_pulses(name, pat, hold, exp);
                end else if (op == "pwm") begin
                    check_pwm(name, exp);
                end else if (op == "seg") begin
                    check_display(name, exp, pat);
                end else begin
                    errors++;
                    $display("unknown operation %s in test %s", op, name);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (records == 0) begin
            errors++;
            $display("no test records were read");
        end
        $display("records %0d, errors %0d, timeouts %0d", records, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== line_tracker_tests.txt ====
# name op pattern(left mid right) hold_clocks expected_state
# op is reset, hold, glitch (hold gives the pulse count), pwm or seg
reset_a      reset  000 0  stop
idle_stop    hold   100 15 stop
start_011    hold   011 20 right
off_line     hold   000 20 right
glitch_a     glitch 000 5  right
pwm_right    pwm    000 0  right
seg_right    seg    000 0  right
mark_short   hold   111 5  straight
pwm_straight pwm    111 0  straight
cross_long   hold   111 60 left
pwm_left     pwm    111 0  left
seg_left     seg    111 0  left
leave_left   hold   010 20 right
reset_b      reset  000 0  stop
start_110    hold   110 20 left
off_line_b   hold   000 20 left
glitch_b     glitch 000 5  left
mark_b       hold   111 5  straight
cross_b      hold   111 60 right
seg_b        seg    111 0  right
leave_right  hold   001 20 left
pwm_left_b   pwm    001 0  left

// ==== sim.f ====
car_cfg_pkg.sv
car_types_pkg.sv
track_sampler.sv
sample_fifo.sv
steering_fsm.sv
motor_pwm.sv
seg_display.sv
line_tracker_top.sv
tb_line_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the line tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -f sim.f --top-module tb_line_tracker -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_line_tracker > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
    exit 1
fi
exit 0
